/* design/alu.sv */
`include "dp_macros.svh"

module alu (
	input  dp_pkg::word_t   a,
	input  dp_pkg::word_t   b,
	input  dp_pkg::alu_op_t op,
	input  logic            inc_pc,
	output dp_pkg::dword_t  res
);
	import dp_pkg::*;

	logic [4:0] sh;
	dword_t     a_ext;
	dword_t     b_ext;
	dword_t     prod;
	dword_t     quo;
	dword_t     rem;
	dword_t     rot_r;
	dword_t     rot_l;

	assign sh = b[4:0]; // shift count.

	// 64-bit signed operands, so min / -1 cannot overflow.
	assign a_ext = {{`DP_WORD_W{a[`DP_WORD_W-1]}}, a};
	assign b_ext = {{`DP_WORD_W{b[`DP_WORD_W-1]}}, b};

	assign prod = $signed(a_ext) * $signed(b_ext);
	assign quo = $signed(a_ext) / $signed(b_ext);
	assign rem = $signed(a_ext) % $signed(b_ext);

	assign rot_r = {a, a} >> sh;
	assign rot_l = {a, a} << sh;

	always_comb begin
		word_t lo_w;
		word_t hi_w;
		lo_w = '0;
		hi_w = '0;
		if (inc_pc) begin
			lo_w = b + 1'b1; // pc increment overrides op.
		end else begin
			case (op)
				`OP_ADD:  lo_w = a + b;
				`OP_SUB:  lo_w = a - b;
				`OP_AND:  lo_w = a & b;
				`OP_OR:   lo_w = a | b;
				`OP_SHR:  lo_w = a >> sh;
				`OP_SHRA: lo_w = $signed(a) >>> sh;
				`OP_SHL:  lo_w = a << sh;
				`OP_ROR:  lo_w = rot_r[`DP_WORD_W-1:0];
				`OP_ROL:  lo_w = rot_l[2*`DP_WORD_W-1:`DP_WORD_W];
				`OP_MUL: begin
					hi_w = prod[2*`DP_WORD_W-1:`DP_WORD_W];
					lo_w = prod[`DP_WORD_W-1:0];
				end
				`OP_DIV: begin
					if (b == '0) begin
						// divide by zero.
						hi_w = a;
						lo_w = '1;
					end else begin
						hi_w = rem[`DP_WORD_W-1:0];
						lo_w = quo[`DP_WORD_W-1:0];
					end
				end
				`OP_NEG:  lo_w = -b;
				`OP_NOT:  lo_w = ~b;
				default:  lo_w = '0;
			endcase
		end
		res = {hi_w, lo_w};
	end

endmodule

/* design/bus_select.sv */
`include "dp_macros.svh"

module bus_select (
	input  dp_pkg::dp_ctrl_t                  ctrl,
	input  dp_pkg::word_t [`DP_NUM_REGS-1:0] gpr,
	input  dp_pkg::word_t                     hi,
	input  dp_pkg::word_t                     lo,
	input  dp_pkg::word_t                     zhi,
	input  dp_pkg::word_t                     zlo,
	input  dp_pkg::word_t                     pc,
	input  dp_pkg::word_t                     mdr,
	input  dp_pkg::word_t                     in_port,
	input  dp_pkg::word_t                     c_const,
	output dp_pkg::word_t                     bus
);

	localparam int NUM_SRC = `DP_NUM_REGS + 8;
	localparam int SRC_W = $clog2(NUM_SRC);
	localparam int IDX_W = $clog2(`DP_NUM_REGS);

	localparam logic [SRC_W-1:0] SRC_HI  = SRC_W'(`DP_NUM_REGS);
	localparam logic [SRC_W-1:0] SRC_LO  = SRC_W'(`DP_NUM_REGS + 1);
	localparam logic [SRC_W-1:0] SRC_ZHI = SRC_W'(`DP_NUM_REGS + 2);
	localparam logic [SRC_W-1:0] SRC_ZLO = SRC_W'(`DP_NUM_REGS + 3);
	localparam logic [SRC_W-1:0] SRC_PC  = SRC_W'(`DP_NUM_REGS + 4);
	localparam logic [SRC_W-1:0] SRC_MDR = SRC_W'(`DP_NUM_REGS + 5);
	localparam logic [SRC_W-1:0] SRC_INP = SRC_W'(`DP_NUM_REGS + 6);
	localparam logic [SRC_W-1:0] SRC_C   = SRC_W'(`DP_NUM_REGS + 7);

	logic [NUM_SRC-1:0] strobes;
	logic [SRC_W-1:0]   src;
	logic               src_vld;

	// bit order is the priority order.
	assign strobes = {ctrl.c_out, ctrl.inport_out, ctrl.mdr_out, ctrl.pc_out,
		ctrl.zlo_out, ctrl.zhi_out, ctrl.lo_out, ctrl.hi_out, ctrl.reg_out};

	always_comb begin
		src = '0;
		src_vld = 1'b0;
		for (int i = NUM_SRC - 1; i >= 0; i--) begin
			if (strobes[i]) begin
				src = SRC_W'(i); // lowest set bit wins.
				src_vld = 1'b1;
			end
		end
	end

	always_comb begin
		bus = '0;
		if (src_vld) begin
			case (src)
				SRC_HI:  bus = hi;
				SRC_LO:  bus = lo;
				SRC_ZHI: bus = zhi;
				SRC_ZLO: bus = zlo;
				SRC_PC:  bus = pc;
				SRC_MDR: bus = mdr;
				SRC_INP: bus = in_port;
				SRC_C:   bus = c_const;
				default: bus = gpr[src[IDX_W-1:0]];
			endcase
		end
	end

	always_comb begin
		assert ($onehot0(strobes)) else $error("bus_select: more than one out strobe");
	end

endmodule

/* design/datapath.sv */
`include "dp_macros.svh"

module datapath (
	input  logic             clk,
	input  logic             rst_n,
	input  dp_pkg::dp_ctrl_t ctrl,
	input  dp_pkg::word_t    md_in,
	input  dp_pkg::word_t    in_port,
	output dp_pkg::word_t    bus
);
	import dp_pkg::*;

	word_t [`DP_NUM_REGS-1:0] gpr;
	word_t  pc;
	word_t  y;
	word_t  zhi;
	word_t  zlo;
	word_t  hi;
	word_t  lo;
	word_t  mdr;
	word_t  c_const;
	dword_t alu_res;

	reg_file i_reg_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.reg_in (ctrl.reg_in),
		.bus    (bus),
		.gpr    (gpr)
	);

	spec_regs i_spec_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (ctrl),
		.bus     (bus),
		.md_in   (md_in),
		.alu_res (alu_res),
		.pc      (pc),
		.y       (y),
		.zhi     (zhi),
		.zlo     (zlo),
		.hi      (hi),
		.lo      (lo),
		.mdr     (mdr),
		.c_const (c_const)
	);

	bus_select i_bus_select (
		.ctrl    (ctrl),
		.gpr     (gpr),
		.hi      (hi),
		.lo      (lo),
		.zhi     (zhi),
		.zlo     (zlo),
		.pc      (pc),
		.mdr     (mdr),
		.in_port (in_port),
		.c_const (c_const),
		.bus     (bus)
	);

	// operand b is always the bus.
	alu i_alu (
		.a      (y),
		.b      (bus),
		.op     (ctrl.op),
		.inc_pc (ctrl.inc_pc),
		.res    (alu_res)
	);

endmodule

/* design/dp_pkg.sv */
`include "dp_macros.svh"

package dp_pkg;

	typedef logic [`DP_WORD_W-1:0] word_t;
	typedef logic [2*`DP_WORD_W-1:0] dword_t; // alu result, z register.
	typedef logic [`DP_NUM_REGS-1:0] reg_mask_t;
	typedef logic [`DP_OP_W-1:0] alu_op_t;

	typedef struct packed {
		reg_mask_t reg_in;
		reg_mask_t reg_out;
		logic      pc_in;
		logic      ir_in;
		logic      y_in;
		logic      z_in;
		logic      hi_in;
		logic      lo_in;
		logic      mdr_in;
		logic      read; // mdr from memory.
		logic      pc_out;
		logic      zhi_out;
		logic      zlo_out;
		logic      hi_out;
		logic      lo_out;
		logic      mdr_out;
		logic      inport_out;
		logic      c_out;
		logic      inc_pc;
		alu_op_t   op;
	} dp_ctrl_t;

endpackage

/* design/reg_file.sv */
`include "dp_macros.svh"

module reg_file (
	input  logic                              clk,
	input  logic                              rst_n,
	input  dp_pkg::reg_mask_t                 reg_in,
	input  dp_pkg::word_t                     bus,
	output dp_pkg::word_t [`DP_NUM_REGS-1:0] gpr
);

	// r0 to r15, each loads the bus on its own strobe.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gpr <= '0;
		end else begin
			for (int k = 0; k < `DP_NUM_REGS; k++) begin
				if (reg_in[k]) begin
					gpr[k] <= bus;
				end
			end
		end
	end

	// at most one register written per cycle.
	a_reg_in_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(reg_in)
	) else $error("reg_file: more than one reg_in strobe set");

endmodule

/* design/spec_regs.sv */
`include "dp_macros.svh"

module spec_regs (
	input  logic             clk,
	input  logic             rst_n,
	input  dp_pkg::dp_ctrl_t ctrl,
	input  dp_pkg::word_t    bus,
	input  dp_pkg::word_t    md_in,
	input  dp_pkg::dword_t   alu_res,
	output dp_pkg::word_t    pc,
	output dp_pkg::word_t    y,
	output dp_pkg::word_t    zhi,
	output dp_pkg::word_t    zlo,
	output dp_pkg::word_t    hi,
	output dp_pkg::word_t    lo,
	output dp_pkg::word_t    mdr,
	output dp_pkg::word_t    c_const
);
	import dp_pkg::*;

	word_t ir;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc  <= '0;
			ir  <= '0;
			y   <= '0;
			zhi <= '0;
			zlo <= '0;
			hi  <= '0;
			lo  <= '0;
			mdr <= '0;
		end else begin
			if (ctrl.pc_in) pc <= bus;
			if (ctrl.ir_in) ir <= bus;
			if (ctrl.y_in) y <= bus; // alu operand a.
			if (ctrl.hi_in) hi <= bus;
			if (ctrl.lo_in) lo <= bus;
			if (ctrl.z_in) begin
				zhi <= alu_res[2*`DP_WORD_W-1:`DP_WORD_W];
				zlo <= alu_res[`DP_WORD_W-1:0];
			end
			if (ctrl.mdr_in) begin
				mdr <= ctrl.read ? md_in : bus;
			end
		end
	end

	// sign-extended constant field.
	assign c_const = {{(`DP_WORD_W-`DP_CONST_W){ir[`DP_CONST_W-1]}}, ir[`DP_CONST_W-1:0]};

	// a memory read needs the mdr load strobe.
	a_read_with_mdr_in: assert property (
		@(posedge clk) disable iff (!rst_n)
		ctrl.read |-> ctrl.mdr_in
	) else $error("spec_regs: read without mdr_in");

endmodule

/* flist.f */
+incdir+include
design/dp_pkg.sv
design/reg_file.sv
design/spec_regs.sv
design/bus_select.sv
design/alu.sv
design/datapath.sv
test/tb_datapath.sv

/* include/dp_macros.svh */
`ifndef DP_MACROS_SVH
`define DP_MACROS_SVH

`define DP_WORD_W   32
`define DP_NUM_REGS 16
`define DP_OP_W     5
`define DP_CONST_W  19 // immediate field in ir.

// alu opcodes.
`define OP_ADD  5'd0
`define OP_SUB  5'd1
`define OP_AND  5'd2
`define OP_OR   5'd3
`define OP_SHR  5'd4
`define OP_SHRA 5'd5
`define OP_SHL  5'd6
`define OP_ROR  5'd7
`define OP_ROL  5'd8
`define OP_MUL  5'd9
`define OP_DIV  5'd10
`define OP_NEG  5'd11
`define OP_NOT  5'd12

`endif

/* run.sh */
#!/bin/sh
# build and run the datapath testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_datapath -o tb_datapath; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_datapath > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi
cat "$LOG"

if grep -q "^TB PASSED$" "$LOG"; then
	exit 0
fi
exit 1

/* test/tb_datapath.sv */
`include "dp_macros.svh"

module tb_datapath;
	timeunit 1ns;
	timeprecision 100ps;
	import dp_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_FIXED = 16;
	localparam int NUM_RAND = 26;
	localparam int NUM_VEC = NUM_FIXED + NUM_RAND;
	localparam int CONST_SH = `DP_WORD_W - `DP_CONST_W;

	// out strobe numbers after the sixteen gpr strobes.
	localparam int S_HI = 16;
	localparam int S_LO = 17;
	localparam int S_ZHI = 18;
	localparam int S_ZLO = 19;
	localparam int S_PC = 20;
	localparam int S_MDR = 21;
	localparam int S_INP = 22;
	localparam int S_C = 23;

	typedef struct packed {
		alu_op_t op;
		word_t   a;
		word_t   b;
		dword_t  exp;
	} alu_vec_t;

	logic     clk;
	logic     rst_n;
	dp_ctrl_t ctrl;
	word_t    md_in;
	word_t    in_port;
	word_t    bus;
	integer   seed;
	alu_vec_t vec [NUM_VEC];

	datapath i_datapath (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (ctrl),
		.md_in   (md_in),
		.in_port (in_port),
		.bus     (bus)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((NUM_VEC * 8 + 50) * CLK_PERIOD);
		$display("timeout: the datapath tests did not finish in time");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	// alu behavior taken from the opcode rules.
	function automatic dword_t alu_model(input alu_op_t op, input word_t a, input word_t b);
		int     n;
		longint sa;
		longint sb;
		word_t  r;
		n = int'(b[4:0]);
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		r = '0;
		case (op)
			`OP_ADD:  r = a + b;
			`OP_SUB:  r = a - b;
			`OP_AND:  r = a & b;
			`OP_OR:   r = a | b;
			`OP_SHR:  r = a >> n;
			`OP_SHRA: r = word_t'(sa >>> n);
			`OP_SHL:  r = a << n;
			`OP_ROR:  r = (n == 0) ? a : (a >> n) | (a << (32 - n));
			`OP_ROL:  r = (n == 0) ? a : (a << n) | (a >> (32 - n));
			`OP_MUL:  return dword_t'(sa * sb);
			`OP_DIV: begin
				if (b == '0) return {a, 32'hffff_ffff}; // divide by zero.
				return {word_t'(sa % sb), word_t'(sa / sb)};
			end
			`OP_NEG:  r = 32'd0 - b;
			`OP_NOT:  r = ~b;
			default:  r = '0;
		endcase
		return {32'd0, r};
	endfunction

	function automatic alu_vec_t make_vec(input alu_op_t op, input word_t a, input word_t b);
		return '{op: op, a: a, b: b, exp: alu_model(op, a, b)};
	endfunction

	function automatic word_t const_model(input word_t ir);
		return word_t'($signed(ir << CONST_SH) >>> CONST_SH);
	endfunction

	function automatic dp_ctrl_t out_strobe(input int s);
		dp_ctrl_t c;
		c = '0;
		case (s)
			S_HI:    c.hi_out = 1'b1;
			S_LO:    c.lo_out = 1'b1;
			S_ZHI:   c.zhi_out = 1'b1;
			S_ZLO:   c.zlo_out = 1'b1;
			S_PC:    c.pc_out = 1'b1;
			S_MDR:   c.mdr_out = 1'b1;
			S_INP:   c.inport_out = 1'b1;
			S_C:     c.c_out = 1'b1;
			default: c.reg_out[s[3:0]] = 1'b1;
		endcase
		return c;
	endfunction

	task automatic build_table();
		word_t a;
		word_t b;
		vec[0]  = make_vec(`OP_ADD,  32'hffff_ffff, 32'h0000_0001);
		vec[1]  = make_vec(`OP_SUB,  32'h0000_0000, 32'h0000_0001);
		vec[2]  = make_vec(`OP_AND,  32'hf0f0_f0f0, 32'h3c3c_3c3c);
		vec[3]  = make_vec(`OP_OR,   32'hf0f0_0000, 32'h0000_3c3c);
		vec[4]  = make_vec(`OP_SHR,  32'h8000_0000, 32'h0000_001f);
		vec[5]  = make_vec(`OP_SHRA, 32'h8000_0000, 32'h0000_0004);
		vec[6]  = make_vec(`OP_SHL,  32'h0000_0001, 32'h0000_001f);
		vec[7]  = make_vec(`OP_ROR,  32'h1234_5678, 32'h0000_0008);
		vec[8]  = make_vec(`OP_ROL,  32'h1234_5678, 32'h0000_0024); // count wraps to 4.
		vec[9]  = make_vec(`OP_MUL,  32'h8000_0000, 32'hffff_ffff);
		vec[10] = make_vec(`OP_MUL,  32'h7fff_ffff, 32'h8000_0001);
		vec[11] = make_vec(`OP_DIV,  32'hffff_fff9, 32'h0000_0002);
		vec[12] = make_vec(`OP_DIV,  32'h8000_0000, 32'hffff_ffff);
		vec[13] = make_vec(`OP_DIV,  32'h1234_5678, 32'h0000_0000);
		vec[14] = make_vec(`OP_NEG,  32'h0000_0005, 32'h8000_0000);
		vec[15] = make_vec(`OP_NOT,  32'hffff_ffff, 32'h5a5a_0f0f);
		for (int i = NUM_FIXED; i < NUM_VEC; i++) begin
			a = $random(seed);
			b = $random(seed);
			vec[i] = make_vec(alu_op_t'(i % 13), a, b);
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s read %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_dword(input dword_t got, input dword_t exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s read %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// strobes change on the falling edge, bus settles a quarter period later.
	task automatic apply(input dp_ctrl_t c, input word_t port, input word_t mem);
		@(negedge clk);
		ctrl = c;
		in_port = port;
		md_in = mem;
		#(CLK_PERIOD / 4);
	endtask

	task automatic read_out(input dp_ctrl_t c, input word_t exp, input string what);
		apply(c, '0, '0);
		check_word(bus, exp, what);
	endtask

	initial begin
		dp_ctrl_t c;
		word_t    vals [`DP_NUM_REGS];
		word_t    lo_rd;
		word_t    hi_rd;
		word_t    v;
		seed = 32'hc58d;
		rst_n = 1'b0;
		ctrl = '0;
		md_in = '0;
		in_port = '0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int s = 0; s < `DP_NUM_REGS + 8; s++) begin
			read_out(out_strobe(s), '0, $sformatf("source %0d after reset", s));
		end

		for (int k = 0; k < `DP_NUM_REGS; k++) begin
			vals[k] = $random(seed);
			c = out_strobe(S_INP);
			c.reg_in[k[3:0]] = 1'b1;
			apply(c, vals[k], '0);
			read_out(out_strobe(k), vals[k], $sformatf("r%0d", k));
		end
		for (int k = 0; k < `DP_NUM_REGS; k++) begin
			read_out(out_strobe(k), vals[k], $sformatf("r%0d held", k)); // no later load touched it.
		end

		foreach (vec[i]) begin
			c = out_strobe(S_INP);
			c.y_in = 1'b1;
			apply(c, vec[i].a, '0);
			c.y_in = 1'b0;
			c.z_in = 1'b1;
			c.op = vec[i].op;
			apply(c, vec[i].b, '0);
			apply(out_strobe(S_ZLO), '0, '0);
			lo_rd = bus;
			apply(out_strobe(S_ZHI), '0, '0);
			hi_rd = bus;
			check_dword({hi_rd, lo_rd}, vec[i].exp,
				$sformatf("alu entry %0d op %0d", i, vec[i].op));
		end

		v = $random(seed);
		c = '0;
		c.mdr_in = 1'b1;
		c.read = 1'b1;
		apply(c, '0, v);
		read_out(out_strobe(S_MDR), v, "mdr from memory");
		c = out_strobe(S_INP);
		c.mdr_in = 1'b1;
		apply(c, ~v, v); // md_in differs, must be ignored.
		read_out(out_strobe(S_MDR), ~v, "mdr from bus");

		v = $random(seed);
		c = out_strobe(S_INP);
		c.pc_in = 1'b1;
		apply(c, v, '0);
		c = out_strobe(S_PC);
		c.inc_pc = 1'b1;
		c.z_in = 1'b1;
		apply(c, '0, '0);
		c = out_strobe(S_ZLO);
		c.pc_in = 1'b1;
		apply(c, '0, '0);
		read_out(out_strobe(S_PC), v + 32'd1, "pc increment");

		for (int j = 0; j < 2; j++) begin
			v = (j == 0) ? 32'habc1_2345 : 32'h0005_4321; // positive, then negative field.
			c = out_strobe(S_INP);
			c.ir_in = 1'b1;
			apply(c, v, '0);
			read_out(out_strobe(S_C), const_model(v), "ir constant");
		end

		v = $random(seed);
		c = out_strobe(S_INP);
		c.hi_in = 1'b1;
		apply(c, v, '0);
		c.hi_in = 1'b0;
		c.lo_in = 1'b1;
		apply(c, ~v, '0);
		read_out(out_strobe(S_HI), v, "hi");
		read_out(out_strobe(S_LO), ~v, "lo");

		@(negedge clk);
		ctrl = '0;
		$display("TB PASSED");
		$finish;
	end

endmodule
